//--- tb.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/pipeStageIf.sv
logic/pipeReg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpuPipe.sv
verif/cpuPipe_chk.sv
verif/cpuPipe_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module cpuPipe_tb -Mdir obj_dir -f tb.f
	./obj_dir/VcpuPipe_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "TEST FAILED"; exit 1; \
	fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir sim.log

//--- verif/cpuPipe_tb.sv
module cpuPipe_tb import isaPkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   // one program word and what it must leave on the trace port
   typedef struct {
      logic [dataW-1:0]    word;
      bit                  retire;
      logic [regAddrW-1:0] dest;
      logic [dataW-1:0]    value;
   } entryT;

   logic                clk;
   logic                reset;
   logic                progWe;
   logic [dataW-1:0]    progAddr;
   logic [dataW-1:0]    progData;
   logic                halted;
   logic                err;
   logic                wbValid;
   logic [regAddrW-1:0] wbReg;
   logic [dataW-1:0]    wbData;

   entryT prog[$];
   int    errors = 0;
   int    checks = 0;
   int    cycleLimit = 1000;
   int    runCycles;

   cpuPipe #(.imemWords(64), .dmemWords(64)) dut_i (
      .clk(clk), .reset(reset), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .halted(halted), .err(err), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

   function automatic logic [dataW-1:0] rType(input opcodeT op, input int rd, input int rs,
                                              input int rt);
      return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
   endfunction

   // imm is the signed six-bit field, also used as the BEQZ offset
   function automatic logic [dataW-1:0] iType(input opcodeT op, input int rd, input int rs,
                                              input int imm);
      return {op, 3'(rd), 3'(rs), 6'(imm)};
   endfunction

   task automatic checkValue(input string name, input logic [dataW-1:0] actual,
                             input logic [dataW-1:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Error: %s is %h, expected %h", name, actual, expected);
      end
   endtask

   task automatic addRetire(input logic [dataW-1:0] word, input int dest,
                            input logic [dataW-1:0] value);
      entryT e;
      e.word = word;
      e.retire = 1'b1;
      e.dest = 3'(dest);
      e.value = value;
      prog.push_back(e);
   endtask

   task automatic addSilent(input logic [dataW-1:0] word);
      entryT e;
      e.word = word;
      e.retire = 1'b0;
      e.dest = '0;
      e.value = '0;
      prog.push_back(e);
   endtask

   task automatic buildMainProgram();
      prog.delete();
      addRetire(rType(opXor, 0, 0, 0), 0, 16'h0000);
      // forwarding from memory, then from writeback
      addRetire(iType(opAddi, 1, 0, 5), 1, 16'h0005);
      addRetire(iType(opAddi, 2, 0, -3), 2, 16'hFFFD);
      addRetire(iType(opAddi, 3, 0, 12), 3, 16'h000C);
      addRetire(rType(opAdd, 4, 1, 3), 4, 16'h0011);
      addRetire(rType(opSub, 5, 1, 2), 5, 16'h0008);
      addRetire(rType(opAnd, 6, 2, 3), 6, 16'h000C);
      addRetire(rType(opXor, 7, 2, 1), 7, 16'hFFF8);
      // back-to-back dependent chain
      addRetire(rType(opAdd, 1, 1, 1), 1, 16'h000A);
      addRetire(rType(opSub, 2, 1, 3), 2, 16'hFFFE);
      addRetire(rType(opXor, 3, 1, 2), 3, 16'hFFF4);
      // store, load back, use at once
      addSilent(iType(opSt, 3, 0, 2));
      addRetire(iType(opLd, 4, 0, 2), 4, 16'hFFF4);
      addRetire(rType(opAdd, 5, 4, 1), 5, 16'hFFFE);
      // r1 is nonzero so this one falls through
      addSilent(iType(opBeqz, 0, 1, 4));
      addRetire(rType(opXor, 6, 6, 6), 6, 16'h0000);
      // taken to pc plus one plus 2, skipping two words
      addSilent(iType(opBeqz, 0, 6, 2));
      addSilent(iType(opAddi, 7, 0, 1));
      addSilent(iType(opAddi, 7, 0, 2));
      addRetire(iType(opAddi, 7, 5, 3), 7, 16'h0001);
      addSilent(iType(opHalt, 0, 0, 0));
      // still in flight behind the halt
      for (int i = 1; i <= 4; i++) begin
         addSilent(iType(opAddi, i, 0, i));
      end
   endtask

   task automatic buildFaultProgram();
      prog.delete();
      addSilent(16'hF000);
      addSilent(iType(opHalt, 0, 0, 0));
      repeat (3) addSilent(iType(opAddi, 1, 0, 1));
   endtask

   // load under reset, release, then follow the trace port until halt settles
   task automatic runProgram();
      int   idx;
      int   settle;
      logic errPrev;
      idx = 0;
      settle = 0;
      errPrev = 1'b0;
      reset = 1'b1;
      foreach (prog[i]) begin
         progWe = 1'b1;
         progAddr = 16'(i);
         progData = prog[i].word;
         @(negedge clk);
      end
      progWe = 1'b0;
      repeat (10) @(negedge clk);
      checkValue("wbValid", 16'(wbValid), 16'd0);
      checkValue("halted", 16'(halted), 16'd0);
      checkValue("err", 16'(err), 16'd0);
      cycleLimit = 4 * prog.size() + 40;
      reset = 1'b0;
      while (settle < 5) begin
         @(negedge clk);
         if (wbValid) begin
            while (idx < prog.size() && !prog[idx].retire) begin
               idx++;
            end
            if (idx < prog.size()) begin
               checkValue("wbReg", 16'(wbReg), 16'(prog[idx].dest));
               checkValue("wbData", wbData, prog[idx].value);
               idx++;
            end else begin
               errors++;
               $display("Unexpected register write to r%0d after the last expected one", wbReg);
            end
         end
         if (errPrev && !err) begin
            errors++;
            $display("err dropped while reset was low");
         end
         errPrev = err;
         if (halted) begin
            settle++;
         end
      end
      while (idx < prog.size() && !prog[idx].retire) begin
         idx++;
      end
      if (idx < prog.size()) begin
         errors++;
         $display("Halted before program entry %0d retired", idx);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // cycle budget per run, restarted by every reset
   initial begin
      runCycles = 0;
      while (runCycles <= cycleLimit) begin
         @(posedge clk);
         if (reset) begin
            runCycles = 0;
         end else begin
            runCycles++;
         end
      end
      $display("Timeout: the core did not halt within %0d cycles", cycleLimit);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Errors found");
      $finish;
   end

   initial begin
      reset = 1'b1;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      @(negedge clk);
      buildMainProgram();
      runProgram();
      checkValue("err", 16'(err), 16'd0);
      buildFaultProgram();
      runProgram();
      checkValue("err", 16'(err), 16'd1);
      checkValue("halted", 16'(halted), 16'd1);
      // sticky flags only clear through reset
      reset = 1'b1;
      repeat (2) @(negedge clk);
      checkValue("err", 16'(err), 16'd0);
      checkValue("halted", 16'(halted), 16'd0);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- verif/cpuPipe_chk.sv
module cpuPipe_chk import isaPkg::*; (
   input logic                clk,
   input logic                reset,
   input logic                halted,
   input logic                wbValid,
   input logic [regAddrW-1:0] wbReg,
   input logic [dataW-1:0]    wbData
);

   timeunit 1ns;
   timeprecision 100ps;

   haltSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
      else $error("halted fell while reset was low");

   // halt parks in writeback, so nothing retires behind it
   quietAfterHalt: assert property (@(posedge clk) disable iff (reset) halted |=> !wbValid)
      else $error("wbValid high after halted");

   traceKnown: assert property (@(posedge clk) disable iff (reset)
      wbValid |-> !$isunknown({wbReg, wbData}))
      else $error("trace port carries unknown bits");

endmodule

bind cpuPipe cpuPipe_chk chk_i (
   .clk(clk), .reset(reset), .halted(halted),
   .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

//--- logic/cpuPipe.sv
module cpuPipe import isaPkg::*, pipePkg::*; #(
   parameter int imemWords = 256,
   parameter int dmemWords = 256
) (
   input logic                 clk,
   input logic                 reset,
   input logic                 progWe,
   input logic [dataW-1:0]     progAddr,
   input logic [dataW-1:0]     progData,
   output logic                halted,
   output logic                err,
   output logic                wbValid,
   output logic [regAddrW-1:0] wbReg,
   output logic [dataW-1:0]    wbData
);

   logic             redirect;
   logic [dataW-1:0] target;
   logic             xIsLoad;

   // each boundary has a side into its register and a side out of it
   pipeStageIf #(.payloadT(fetchPayloadT))  f2dIn ();
   pipeStageIf #(.payloadT(fetchPayloadT))  f2dOut ();
   pipeStageIf #(.payloadT(decodePayloadT)) d2xIn ();
   pipeStageIf #(.payloadT(decodePayloadT)) d2xOut ();
   pipeStageIf #(.payloadT(execPayloadT))   x2mIn ();
   pipeStageIf #(.payloadT(execPayloadT))   x2mOut ();
   pipeStageIf #(.payloadT(memPayloadT))    m2wIn ();
   pipeStageIf #(.payloadT(memPayloadT))    m2wOut ();

   fetchStage #(.imemWords(imemWords)) fetchUnit (
      .clk(clk), .reset(reset), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .redirect(redirect), .target(target), .halt(halted), .out(f2dIn));

   pipeReg #(.payloadT(fetchPayloadT)) f2dReg (
      .clk(clk), .reset(reset), .in(f2dIn), .out(f2dOut));

   decodeStage decodeUnit (
      .clk(clk), .reset(reset), .in(f2dOut), .out(d2xIn), .wb(m2wOut),
      .xDest(d2xOut.payload.rd), .xIsLoad(xIsLoad), .err(err));

   pipeReg #(.payloadT(decodePayloadT)) d2xReg (
      .clk(clk), .reset(reset), .in(d2xIn), .out(d2xOut));

   executeStage executeUnit (
      .in(d2xOut), .out(x2mIn),
      .memFwd(x2mOut.payload), .memFwdValid(x2mOut.valid),
      .wbFwd(m2wOut.payload), .wbFwdValid(m2wOut.valid),
      .redirect(redirect), .target(target));

   pipeReg #(.payloadT(execPayloadT)) x2mReg (
      .clk(clk), .reset(reset), .in(x2mIn), .out(x2mOut));

   memoryStage #(.dmemWords(dmemWords)) memoryUnit (
      .clk(clk), .in(x2mOut), .out(m2wIn));

   pipeReg #(.payloadT(memPayloadT)) m2wReg (
      .clk(clk), .reset(reset), .in(m2wIn), .out(m2wOut));

   assign xIsLoad = d2xOut.valid && d2xOut.payload.opcode == opLd;

   // trace port straight off the writeback side
   assign halted = m2wOut.valid && m2wOut.payload.isHalt;
   assign wbValid = m2wOut.valid && m2wOut.payload.regWe;
   assign wbReg = m2wOut.payload.rd;
   assign wbData = m2wOut.payload.result;

endmodule

//--- logic/memoryStage.sv
module memoryStage import isaPkg::*; #(
   parameter int dmemWords = 256
) (
   input logic          clk,
   pipeStageIf.consumer in,
   pipeStageIf.producer out
);

   localparam int dmemAw = $clog2(dmemWords);

   logic [dataW-1:0]  dmem [dmemWords];
   logic [dmemAw-1:0] addr;

   assign addr = in.payload.result[dmemAw-1:0];

   // store commits only when the instruction moves on
   always_ff @(posedge clk) begin
      if (in.valid && out.ready && in.payload.opcode == opSt) begin
         dmem[addr] <= in.payload.storeData;
      end
   end

   always_comb begin
      out.payload.rd = in.payload.rd;
      out.payload.regWe = in.payload.regWe;
      out.payload.result = (in.payload.opcode == opLd) ? dmem[addr] : in.payload.result;
      out.payload.isHalt = in.payload.opcode == opHalt;
   end

   assign out.valid = in.valid;
   assign out.flush = in.flush;
   assign in.ready = out.ready;

endmodule

//--- logic/executeStage.sv
module executeStage import isaPkg::*, pipePkg::*; (
   pipeStageIf.consumer     in,
   pipeStageIf.producer     out,
   input execPayloadT       memFwd,
   input logic              memFwdValid,
   input memPayloadT        wbFwd,
   input logic              wbFwdValid,
   output logic             redirect,
   output logic [dataW-1:0] target
);

   fwdSelT           selA;
   fwdSelT           selB;
   logic [dataW-1:0] opA;
   logic [dataW-1:0] opB;
   logic [dataW-1:0] aluResult;
   logic             taken;

   // youngest producer first, a load only counts once it reaches writeback
   function automatic fwdSelT pickSource(input logic [regAddrW-1:0] src);
      if (memFwdValid && memFwd.regWe && memFwd.opcode != opLd && memFwd.rd == src) begin
         return fwdMem;
      end
      if (wbFwdValid && wbFwd.regWe && wbFwd.rd == src) begin
         return fwdWb;
      end
      return fwdReg;
   endfunction

   function automatic logic [dataW-1:0] operand(input fwdSelT sel,
                                                input logic [dataW-1:0] regVal);
      case (sel)
         fwdMem: return memFwd.result;
         fwdWb: return wbFwd.result;
         default: return regVal;
      endcase
   endfunction

   always_comb begin
      selA = pickSource(in.payload.srcA);
      selB = pickSource(in.payload.srcB);
      opA = operand(selA, in.payload.srcAVal);
      opB = operand(selB, in.payload.srcBVal);
   end

   always_comb begin
      case (in.payload.opcode)
         opAdd: aluResult = opA + opB;
         opSub: aluResult = opA - opB;
         opAnd: aluResult = opA & opB;
         opXor: aluResult = opA ^ opB;
         // address generation shares the immediate adder
         opAddi, opLd, opSt: aluResult = opA + in.payload.imm;
         default: aluResult = '0;
      endcase
   end

   // not-taken prediction, so only a taken BEQZ redirects
   assign taken = in.valid && in.payload.opcode == opBeqz && opA == '0;
   assign redirect = taken && out.ready;
   assign target = in.payload.pcPlusOne + in.payload.imm;

   always_comb begin
      out.payload.opcode = in.payload.opcode;
      out.payload.rd = in.payload.rd;
      out.payload.regWe = in.payload.regWe;
      out.payload.result = aluResult;
      out.payload.storeData = opB;
   end

   assign out.valid = in.valid;
   assign out.flush = 1'b0;
   assign in.ready = out.ready;

endmodule

//--- logic/decodeStage.sv
module decodeStage import isaPkg::*; (
   input logic                clk,
   input logic                reset,
   pipeStageIf.consumer       in,
   pipeStageIf.producer       out,
   pipeStageIf.consumer       wb,
   input logic [regAddrW-1:0] xDest,
   input logic                xIsLoad,
   output logic               err
);

   logic [dataW-1:0]    regs [1 << regAddrW];
   opcodeT              opcode;
   logic [regAddrW-1:0] rd;
   logic [regAddrW-1:0] srcA;
   logic [regAddrW-1:0] srcB;
   logic                legal;
   logic                regWe;
   logic                usesA;
   logic                usesB;
   logic                stall;
   logic                wbWrite;

   // register read with same-cycle writeback bypass
   function automatic logic [dataW-1:0] readReg(input logic [regAddrW-1:0] idx);
      if (wbWrite && wb.payload.rd == idx) begin
         return wb.payload.result;
      end
      return regs[idx];
   endfunction

   assign wbWrite = wb.valid && wb.payload.regWe;

   always_ff @(posedge clk) begin
      if (wbWrite) begin
         regs[wb.payload.rd] <= wb.payload.result;
      end
   end

   always_comb begin
      opcode = opcodeT'(in.payload.instr[opcodeHi:opcodeLo]);
      rd = in.payload.instr[rdHi:rdLo];
      srcA = in.payload.instr[rsHi:rsLo];
      // a store reads rd as its data source
      srcB = (opcode == opSt) ? rd : in.payload.instr[rtHi:rtLo];
      legal = 1'b1;
      regWe = 1'b0;
      usesB = 1'b0;
      case (opcode)
         opAdd, opSub, opAnd, opXor: begin
            regWe = 1'b1;
            usesB = 1'b1;
         end
         opAddi, opLd: regWe = 1'b1;
         opSt: usesB = 1'b1;
         opBeqz, opHalt: ;
         default: legal = 1'b0;
      endcase
      usesA = legal && opcode != opHalt;
   end

   // load in execute feeding one of our sources costs a bubble
   assign stall = in.valid && xIsLoad &&
                  ((usesA && xDest == srcA) || (usesB && xDest == srcB));

   always_comb begin
      out.payload.opcode = opcode;
      out.payload.rd = rd;
      out.payload.srcA = srcA;
      out.payload.srcB = srcB;
      out.payload.srcAVal = readReg(srcA);
      out.payload.srcBVal = readReg(srcB);
      out.payload.imm = {{(dataW - immHi - 1){in.payload.instr[immHi]}},
                         in.payload.instr[immHi:immLo]};
      out.payload.pcPlusOne = in.payload.pcPlusOne;
      out.payload.regWe = regWe && legal;
   end

   assign out.valid = in.valid && !stall;
   assign out.flush = in.flush;
   assign in.ready = out.ready && !stall;
   // a halt parked in writeback freezes everything behind it
   assign wb.ready = !(wb.valid && wb.payload.isHalt);

   always_ff @(posedge clk) begin
      if (reset) begin
         err <= 1'b0;
      end else if (in.valid && !in.flush && !legal) begin
         err <= 1'b1;
      end
   end

endmodule

//--- logic/fetchStage.sv
module fetchStage import isaPkg::*; #(
   parameter int imemWords = 256
) (
   input logic             clk,
   input logic             reset,
   input logic             progWe,
   input logic [dataW-1:0] progAddr,
   input logic [dataW-1:0] progData,
   input logic             redirect,
   input logic [dataW-1:0] target,
   input logic             halt,
   pipeStageIf.producer    out
);

   localparam int imemAw = $clog2(imemWords);

   logic [dataW-1:0] imem [imemWords];
   logic [dataW-1:0] pc;
   logic             haltSeen;

   // program load port, only open while reset is held
   always_ff @(posedge clk) begin
      if (reset && progWe) begin
         imem[progAddr[imemAw-1:0]] <= progData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         haltSeen <= 1'b0;
      end else begin
         if (halt) begin
            haltSeen <= 1'b1;
         end
         // redirect beats a decode stall
         if (redirect) begin
            pc <= target;
         end else if (out.valid && out.ready) begin
            pc <= pc + 1'b1;
         end
      end
   end

   assign out.valid = ~haltSeen;
   assign out.payload.instr = imem[pc[imemAw-1:0]];
   assign out.payload.pcPlusOne = pc + 1'b1;
   assign out.flush = redirect;

endmodule

//--- logic/pipeReg.sv
module pipeReg #(
   parameter type payloadT = logic
) (
   input logic           clk,
   input logic           reset,
   pipeStageIf.consumer  in,
   pipeStageIf.producer  out
);

   payloadT payloadQ;
   logic    validQ;

   // flush wins over a hold from downstream
   always_ff @(posedge clk) begin
      if (reset || in.flush) begin
         validQ <= 1'b0;
      end else if (out.ready) begin
         validQ <= in.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (out.ready) begin
         payloadQ <= in.payload;
      end
   end

   assign out.valid = validQ;
   assign out.payload = payloadQ;
   // flush travels on so the next stage can squash its own output
   assign out.flush = in.flush;
   assign in.ready = out.ready;

endmodule

//--- logic/pipeStageIf.sv
interface pipeStageIf #(
   parameter type payloadT = logic
);

   logic    valid;
   logic    ready;
   logic    flush;
   payloadT payload;

   modport producer (output valid, output payload, output flush, input ready);

   modport consumer (input valid, input payload, input flush, output ready);

endinterface

//--- logic/pipePkg.sv
package pipePkg;

   import isaPkg::*;

   // fetch to decode
   typedef struct packed {
      logic [dataW-1:0] instr;
      logic [dataW-1:0] pcPlusOne;
   } fetchPayloadT;

   // decode to execute
   // srcB is rt for ALU ops and rd for a store
   typedef struct packed {
      opcodeT                opcode;
      logic [regAddrW-1:0]   rd;
      logic [regAddrW-1:0]   srcA;
      logic [regAddrW-1:0]   srcB;
      logic [dataW-1:0]      srcAVal;
      logic [dataW-1:0]      srcBVal;
      logic [dataW-1:0]      imm;
      logic [dataW-1:0]      pcPlusOne;
      logic                  regWe;
   } decodePayloadT;

   // execute to memory, result holds the address for LD and ST
   typedef struct packed {
      opcodeT                opcode;
      logic [regAddrW-1:0]   rd;
      logic                  regWe;
      logic [dataW-1:0]      result;
      logic [dataW-1:0]      storeData;
   } execPayloadT;

   // memory to writeback
   typedef struct packed {
      logic [regAddrW-1:0]   rd;
      logic                  regWe;
      logic [dataW-1:0]      result;
      logic                  isHalt;
   } memPayloadT;

   // operand source in execute
   typedef enum logic [1:0] {
      fwdReg = 2'd0,
      fwdMem = 2'd1,
      fwdWb  = 2'd2
   } fwdSelT;

endpackage

//--- logic/isaPkg.sv
package isaPkg;

   // machine widths
   localparam int dataW = 16;
   localparam int regAddrW = 3;

   // opcode encodings, the remaining codes are illegal
   typedef enum logic [3:0] {
      opAdd  = 4'h0,
      opSub  = 4'h1,
      opAnd  = 4'h2,
      opXor  = 4'h3,
      opAddi = 4'h4,
      opLd   = 4'h5,
      opSt   = 4'h6,
      opBeqz = 4'h7,
      opHalt = 4'h8
   } opcodeT;

   // instruction field positions
   localparam int opcodeHi = 15;
   localparam int opcodeLo = 12;
   localparam int rdHi = 11;
   localparam int rdLo = 9;
   localparam int rsHi = 8;
   localparam int rsLo = 6;
   localparam int rtHi = 5;
   localparam int rtLo = 3;
   // signed, also the BEQZ offset from pc plus one
   localparam int immHi = 5;
   localparam int immLo = 0;

endpackage
